// ==== Bender.yml ====
package:
  name: credit_link

sources:
  - logic/credit_link_pkg.sv
  - logic/credit_tx.sv
  - logic/rx_buffer.sv
  - logic/credit_return.sv
  - logic/credit_link_top.sv
  - target: test
    files:
      - verif/credit_link_checker.sv
      - verif/credit_link_tb.sv

// ==== filelist.f ====
logic/credit_link_pkg.sv
logic/credit_tx.sv
logic/rx_buffer.sv
logic/credit_return.sv
logic/credit_link_top.sv
verif/credit_link_checker.sv
verif/credit_link_tb.sv

// ==== logic/credit_link_pkg.sv ====
// shared constants and types of the credit-based link endpoint
package credit_link_pkg;

  // width of one payload word carried on the link
  localparam int unsigned DATA_W = 16;

  // depth of the receive buffer, which is also the number of credits the
  // remote side starts with after reset
  localparam int unsigned NUM_CREDITS = 8;

  // once this many released entries are waiting to go back, the transmitter
  // sends credits-only packets if it has no data to send
  localparam int unsigned FORCE_SEND_THRESH = 4;

  // a credit count must hold zero up to NUM_CREDITS
  localparam int unsigned CRED_W = 4;

  // buffer index, wide enough for NUM_CREDITS entries
  localparam int unsigned PTR_W = 3;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CRED_W-1:0] credit_t;
  typedef logic [PTR_W-1:0]  ptr_t;

  // source of the outgoing packet, either the application or a credits-only return
  typedef enum logic {
    PKT_NORMAL    = 1'b0,
    PKT_CRED_ONLY = 1'b1
  } pkt_mode_e;

endpackage

// ==== logic/credit_link_top.sv ====
`timescale 1ns/1ns

// one endpoint of the credit-based link
module credit_link_top import credit_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // application stream into the link
  input  logic    in_valid_i,
  input  data_t   in_data_i,
  output logic    in_ready_o,
  // outgoing link channel
  output logic    tx_valid_o,
  output data_t   tx_data_o,
  output credit_t tx_credits_o,
  output logic    tx_cred_only_o,
  input  logic    tx_ready_i,
  // incoming link channel, no ready since space is covered by credits
  input  logic    rx_valid_i,
  input  data_t   rx_data_i,
  input  credit_t rx_credits_i,
  input  logic    rx_cred_only_i,
  // application stream out of the receive buffer
  output logic    out_valid_o,
  output data_t   out_data_o,
  input  logic    out_ready_i
);

  logic    buf_release;
  logic    tx_fire;
  logic    tx_stall;
  credit_t credits_to_send;

  // the returned credit field is the visible count of credit_return
  assign tx_credits_o = credits_to_send;

  credit_tx u_credit_tx (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .in_valid_i        (in_valid_i),
    .in_data_i         (in_data_i),
    .in_ready_o        (in_ready_o),
    .tx_ready_i        (tx_ready_i),
    .tx_valid_o        (tx_valid_o),
    .tx_data_o         (tx_data_o),
    .tx_cred_only_o    (tx_cred_only_o),
    .rx_valid_i        (rx_valid_i),
    .rx_credits_i      (rx_credits_i),
    .credits_to_send_i (credits_to_send),
    .tx_fire_o         (tx_fire),
    .tx_stall_o        (tx_stall)
  );

  rx_buffer u_rx_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rx_valid_i     (rx_valid_i),
    .rx_cred_only_i (rx_cred_only_i),
    .rx_data_i      (rx_data_i),
    .out_ready_i    (out_ready_i),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .buf_release_o  (buf_release)
  );

  credit_return u_credit_return (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .buf_release_i     (buf_release),
    .tx_fire_i         (tx_fire),
    .tx_stall_i        (tx_stall),
    .credits_to_send_o (credits_to_send)
  );

endmodule

// ==== logic/credit_return.sv ====
`timescale 1ns/1ns

// counts buffer entries released since the last credit return
// the visible count is what goes out on the link, the shadow count collects
// releases while a packet waits so the outgoing credit field stays frozen
module credit_return import credit_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    buf_release_i,
  input  logic    tx_fire_i,
  input  logic    tx_stall_i,
  output credit_t credits_to_send_o
);

  credit_t visible_q, visible_d;
  credit_t shadow_q, shadow_d;
  credit_t release_inc;

  assign release_inc = credit_t'(buf_release_i);

  always_comb begin
    visible_d = visible_q;
    shadow_d  = shadow_q;
    if (tx_fire_i) begin
      // the visible count just left with the packet
      // restart it from what piled up behind it plus this cycle's release
      visible_d = release_inc + shadow_q;
      shadow_d  = '0;
    end else if (tx_stall_i) begin
      // a packet is waiting, do not touch the field it carries
      shadow_d = shadow_q + release_inc;
    end else begin
      visible_d = visible_q + release_inc;
    end
  end

  assign credits_to_send_o = visible_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      visible_q <= '0;
      shadow_q  <= '0;
    end else begin
      visible_q <= visible_d;
      shadow_q  <= shadow_d;
    end
  end

endmodule

// ==== logic/credit_tx.sv ====
`timescale 1ns/1ns

// transmit side of the endpoint
// it decides between data and credits-only packets, keeps the count of
// credits available at the remote buffer and drives the outgoing link handshake
module credit_tx import credit_link_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    in_valid_i,
  input  data_t   in_data_i,
  output logic    in_ready_o,
  input  logic    tx_ready_i,
  output logic    tx_valid_o,
  output data_t   tx_data_o,
  output logic    tx_cred_only_o,
  input  logic    rx_valid_i,
  input  credit_t rx_credits_i,
  input  credit_t credits_to_send_i,
  output logic    tx_fire_o,
  output logic    tx_stall_o
);

  pkt_mode_e mode_q, mode_d;
  credit_t   avail_q, avail_d;
  credit_t   avail_inc, avail_dec;
  logic      cred_only;
  logic      can_send_data;
  logic      force_send;

  assign cred_only = (mode_q == PKT_CRED_ONLY);

  ////////////////////////////////////////////////////////////////////////////
  // packet selection
  ////////////////////////////////////////////////////////////////////////////

  // a data packet needs one credit at the far end
  // the last credit may only be spent when credits travel back with it,
  // otherwise both sides could end up waiting on each other forever
  always_comb begin
    can_send_data = 1'b0;
    if (avail_q > credit_t'(1)) begin
      can_send_data = 1'b1;
    end else if ((avail_q == credit_t'(1)) && (credits_to_send_i != '0)) begin
      can_send_data = 1'b1;
    end
  end

  // too many released entries are piling up on this side
  assign force_send = (credits_to_send_i >= credit_t'(FORCE_SEND_THRESH));

  // credits-only packets never land in the remote buffer, so they are always allowed
  assign tx_valid_o = cred_only ? 1'b1 : (in_valid_i & can_send_data);

  // the application word is accepted only when it really goes out as data
  assign in_ready_o = tx_ready_i & ~cred_only & can_send_data;

  // zero payload on credits-only packets keeps the data field stable and clean
  assign tx_data_o      = cred_only ? '0 : in_data_i;
  assign tx_cred_only_o = cred_only;

  assign tx_fire_o  = tx_valid_o & tx_ready_i;
  assign tx_stall_o = tx_valid_o & ~tx_ready_i;

  // switch to credits-only only while nothing is offered on the link,
  // so a pending packet never changes its type during a stall
  // in normal mode tx_valid_o low already means no data can be sent
  always_comb begin
    mode_d = mode_q;
    if (force_send && !tx_valid_o) begin
      mode_d = PKT_CRED_ONLY;
    end else if (tx_fire_o) begin
      mode_d = PKT_NORMAL;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // available credit counter
  ////////////////////////////////////////////////////////////////////////////

  // credits come back on every valid incoming packet, data or credits-only
  assign avail_inc = rx_valid_i ? rx_credits_i : '0;

  // only data packets occupy a remote buffer entry
  assign avail_dec = (tx_fire_o && !cred_only) ? credit_t'(1) : '0;

  assign avail_d = avail_q + avail_inc - avail_dec;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q  <= PKT_NORMAL;
      avail_q <= credit_t'(NUM_CREDITS);
    end else begin
      mode_q  <= mode_d;
      avail_q <= avail_d;
    end
  end

endmodule

// ==== logic/rx_buffer.sv ====
`timescale 1ns/1ns

// receive buffer of the endpoint
// a circular FIFO with one entry per credit handed to the remote side
module rx_buffer import credit_link_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  rx_valid_i,
  input  logic  rx_cred_only_i,
  input  data_t rx_data_i,
  input  logic  out_ready_i,
  output logic  out_valid_o,
  output data_t out_data_o,
  output logic  buf_release_o
);

  data_t   mem_q [NUM_CREDITS];
  ptr_t    wr_ptr_q, rd_ptr_q;
  credit_t fill_q;
  logic    push;
  logic    pop;

  // credits-only packets carry no payload and are dropped here
  // no full check is needed, the remote side never has more credits than entries
  assign push = rx_valid_i & ~rx_cred_only_i;
  assign pop  = out_valid_o & out_ready_i;

  assign out_valid_o = (fill_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  // every freed entry is one credit to hand back
  assign buf_release_o = pop;

  // pointer step with wrap at the buffer depth
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(NUM_CREDITS - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      fill_q <= fill_q + credit_t'(push) - credit_t'(pop);
    end
  end

  // storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rx_data_i;
    end
  end

endmodule

// ==== verif/credit_link_checker.sv ====
`timescale 1ns/1ns

// watches the endpoint ports and compares them against the link rules
// all values are sampled on the rising edge, before any input changes
module credit_link_checker import credit_link_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        in_valid_i,
  input  logic        in_ready_i,
  input  data_t       in_data_i,
  input  logic        tx_valid_i,
  input  logic        tx_ready_i,
  input  data_t       tx_data_i,
  input  credit_t     tx_credits_i,
  input  logic        tx_cred_only_i,
  input  logic        rx_valid_i,
  input  logic        rx_cred_only_i,
  input  logic        out_valid_i,
  input  logic        out_ready_i,
  input  data_t       out_data_i,
  input  logic        end_check_i,
  output int unsigned errors_o,
  output int unsigned checks_o,
  output int unsigned pops_o,
  output int unsigned cred_only_o
);

  data_t       exp_q [$];
  int unsigned err_cnt;
  int unsigned chk_cnt;
  // pops, data packets sent, data packets received and credits sent back
  int unsigned pops;
  int unsigned data_tx;
  int unsigned rx_pushes;
  int unsigned credit_sum;
  int unsigned cred_only_cnt;
  logic        prev_stall;
  data_t       prev_data;
  credit_t     prev_credits;
  logic        prev_cred_only;

  task automatic same_value(input string test, input int unsigned exp, input int unsigned act);
    chk_cnt++;
    if (exp != act) begin
      err_cnt++;
      $display("FAIL %s at %0t: expected %0d, actual %0d", test, $time, exp, act);
    end
  endtask

  task automatic not_above(input string test, input int unsigned lim, input int unsigned act);
    chk_cnt++;
    if (act > lim) begin
      err_cnt++;
      $display("FAIL %s at %0t: expected at most %0d, actual %0d", test, $time, lim, act);
    end
  endtask

  task automatic not_below(input string test, input int unsigned lim, input int unsigned act);
    chk_cnt++;
    if (act < lim) begin
      err_cnt++;
      $display("FAIL %s at %0t: expected at least %0d, actual %0d", test, $time, lim, act);
    end
  endtask

  task automatic log_problem(input string what);
    err_cnt++;
    $display("%s at %0t", what, $time);
  endtask

  always @(posedge clk_i) begin : watch
    int unsigned pending;
    int unsigned fill;
    data_t       expected;
    if (!rst_n_i) begin
      same_value("reset_tx_valid", 0, tx_valid_i);
      same_value("reset_out_valid", 0, out_valid_i);
      same_value("reset_tx_credits", 0, tx_credits_i);
      same_value("reset_cred_only", 0, tx_cred_only_i);
      exp_q.delete();
      pops          = 0;
      data_tx       = 0;
      rx_pushes     = 0;
      credit_sum    = 0;
      cred_only_cnt = 0;
      prev_stall    = 1'b0;
    end else begin
      // released entries not yet carried back, and entries held in the buffer
      pending = pops - credit_sum;
      fill    = rx_pushes - pops;
      same_value("out_valid", (fill != 0), out_valid_i);
      not_above("credit_field", pending, tx_credits_i);
      // a stalled packet must stay exactly as it was offered
      if (prev_stall) begin
        same_value("stall_valid", 1, tx_valid_i);
        same_value("stall_data", prev_data, tx_data_i);
        same_value("stall_credits", prev_credits, tx_credits_i);
        same_value("stall_cred_only", prev_cred_only, tx_cred_only_i);
      end
      prev_stall     = tx_valid_i && !tx_ready_i;
      prev_data      = tx_data_i;
      prev_credits   = tx_credits_i;
      prev_cred_only = tx_cred_only_i;
      if (tx_valid_i && tx_ready_i) begin
        credit_sum += tx_credits_i;
        if (tx_cred_only_i) begin
          cred_only_cnt++;
          same_value("cred_only_data", 0, tx_data_i);
          not_below("cred_only_threshold", FORCE_SEND_THRESH, pending);
        end else begin
          data_tx++;
        end
      end
      if (in_valid_i && in_ready_i) begin
        exp_q.push_back(in_data_i);
      end
      if (rx_valid_i && !rx_cred_only_i) begin
        rx_pushes++;
      end
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          log_problem("a word came out of the buffer although none was sent");
        end else begin
          expected = exp_q.pop_front();
          same_value("order_integrity", expected, out_data_i);
        end
        pops++;
      end
      not_above("no_overflow", NUM_CREDITS, data_tx - pops);
      if (end_check_i) begin
        if (exp_q.size() != 0) begin
          log_problem($sformatf("%0d words were never delivered", exp_q.size()));
        end
        same_value("all_delivered", data_tx, pops);
        not_above("credit_conservation", FORCE_SEND_THRESH - 1, pops - credit_sum);
        same_value("idle_credit_field", pops - credit_sum, tx_credits_i);
      end
    end
    errors_o    <= err_cnt;
    checks_o    <= chk_cnt;
    pops_o      <= pops;
    cred_only_o <= cred_only_cnt;
  end

endmodule

// ==== verif/credit_link_tb.sv ====
`timescale 1ns/1ns

// testbench of the credit link endpoint
// the outgoing link is looped back onto the incoming one, so the endpoint
// spends its own credits and gets them back through its own receive buffer
module credit_link_tb import credit_link_pkg::*; ();

  localparam int unsigned NUM_PHASES    = 6;
  localparam int unsigned PHASE_TIMEOUT = 5000;
  localparam int unsigned IDLE_CYCLES   = 40;

  typedef struct {
    string       name;
    int unsigned words;
    int unsigned in_pct;
    int unsigned tx_pct;
    int unsigned out_pct;
    int unsigned delay;
  } phase_t;

  // name, words, in_valid %, tx_ready %, out_ready %, loopback delay in cycles
  phase_t phases [NUM_PHASES] = '{
    '{"smoke",            16, 100, 100, 100,  1},
    '{"tx_backpressure",  40,  80,  30,  90,  2},
    '{"out_backpressure", 40,  90,  90,  15,  3},
    '{"random_mix",       60,  50,  60,  60,  5},
    '{"long_loop",        30, 100, 100, 100, 12},
    '{"sparse",           20,  20,  70,  50,  1}
  };

  // a packet travelling back through the loopback
  // due is the cycle on which it shows up at the rx ports
  typedef struct packed {
    logic [31:0] due;
    data_t       data;
    credit_t     credits;
    logic        cred_only;
  } loop_pkt_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        in_valid_i;
  data_t       in_data_i;
  logic        in_ready_o;
  logic        tx_valid_o;
  data_t       tx_data_o;
  credit_t     tx_credits_o;
  logic        tx_cred_only_o;
  logic        tx_ready_i;
  logic        rx_valid_i;
  data_t       rx_data_i;
  credit_t     rx_credits_i;
  logic        rx_cred_only_i;
  logic        out_valid_o;
  data_t       out_data_o;
  logic        out_ready_i;

  loop_pkt_t   loop_q [$];
  logic [31:0] lcg_state;
  logic [31:0] cycle_cnt = '0;
  int unsigned words_sent = 0;
  int unsigned word_target = 0;
  int unsigned in_pct = 0;
  int unsigned tx_pct = 0;
  int unsigned out_pct = 0;
  int unsigned loop_delay = 1;
  logic        end_check = 1'b0;
  logic        timed_out = 1'b0;
  int unsigned errors;
  int unsigned checks;
  int unsigned pops;
  int unsigned cred_only_cnt;

  credit_link_top u_dut (.*);

  credit_link_checker u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_i     (in_ready_o),
    .in_data_i      (in_data_i),
    .tx_valid_i     (tx_valid_o),
    .tx_ready_i     (tx_ready_i),
    .tx_data_i      (tx_data_o),
    .tx_credits_i   (tx_credits_o),
    .tx_cred_only_i (tx_cred_only_o),
    .rx_valid_i     (rx_valid_i),
    .rx_cred_only_i (rx_cred_only_i),
    .out_valid_i    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_data_i     (out_data_o),
    .end_check_i    (end_check),
    .errors_o       (errors),
    .checks_o       (checks),
    .pops_o         (pops),
    .cred_only_o    (cred_only_cnt)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // true with the given percentage, taken from the upper LCG bits
  function automatic logic chance(input int unsigned pct);
    logic [31:0] r;
    r = lcg_next();
    return (r[31:16] % 100) < pct;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // input driver and loopback link
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : drive_link
    logic        accepted;
    int unsigned sent_next;
    loop_pkt_t   pkt;
    if (rst_n_i) begin
      accepted  = in_valid_i && in_ready_o;
      sent_next = words_sent + (accepted ? 1 : 0);
      cycle_cnt   <= cycle_cnt + 1;
      words_sent  <= sent_next;
      tx_ready_i  <= chance(tx_pct);
      out_ready_i <= chance(out_pct);
      // an offered word holds valid and data until it is taken
      if (accepted || !in_valid_i) begin
        if ((sent_next < word_target) && chance(in_pct)) begin
          in_valid_i <= 1'b1;
          in_data_i  <= data_t'(lcg_next() >> 16);
        end else begin
          in_valid_i <= 1'b0;
        end
      end
      if (tx_valid_o && tx_ready_i) begin
        pkt.due       = cycle_cnt + loop_delay;
        pkt.data      = tx_data_o;
        pkt.credits   = tx_credits_o;
        pkt.cred_only = tx_cred_only_o;
        loop_q.push_back(pkt);
      end
      // the rx channel has no ready so at most one packet lands per cycle
      if ((loop_q.size() != 0) && (loop_q[0].due <= cycle_cnt)) begin
        pkt = loop_q.pop_front();
        rx_valid_i     <= 1'b1;
        rx_data_i      <= pkt.data;
        rx_credits_i   <= pkt.credits;
        rx_cred_only_i <= pkt.cred_only;
      end else begin
        rx_valid_i     <= 1'b0;
        rx_data_i      <= '0;
        rx_credits_i   <= '0;
        rx_cred_only_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // phase sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_phase(input int unsigned idx);
    int unsigned target;
    int unsigned waited;
    target = word_target + phases[idx].words;
    $display("phase %s with %0d words", phases[idx].name, phases[idx].words);
    in_pct      <= phases[idx].in_pct;
    tx_pct      <= phases[idx].tx_pct;
    out_pct     <= phases[idx].out_pct;
    loop_delay  <= phases[idx].delay;
    word_target <= target;
    waited = 0;
    while ((words_sent < target) && (waited < PHASE_TIMEOUT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (words_sent < target) begin
      $display("timeout in phase %s, only %0d of %0d words were accepted",
               phases[idx].name, words_sent, target);
      timed_out = 1'b1;
    end
  endtask

  // let the buffer drain, give the idle credit return time, then wait until
  // the link has been quiet for a few cycles
  task automatic drain_and_settle();
    int unsigned waited;
    int unsigned quiet;
    in_pct  <= 0;
    tx_pct  <= 100;
    out_pct <= 100;
    waited = 0;
    while ((pops != words_sent) && (waited < PHASE_TIMEOUT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (pops != words_sent) begin
      $display("timeout while draining, %0d of %0d words came out", pops, words_sent);
      timed_out = 1'b1;
    end
    repeat (IDLE_CYCLES) @(negedge clk_i);
    quiet  = 0;
    waited = 0;
    while ((quiet < 4) && (waited < PHASE_TIMEOUT)) begin
      @(negedge clk_i);
      waited++;
      quiet = ((loop_q.size() == 0) && !rx_valid_i && !tx_valid_o) ? quiet + 1 : 0;
    end
    if (quiet < 4) begin
      $display("timeout while waiting for the link to go idle");
      timed_out = 1'b1;
    end
  endtask

  initial begin : run_test
    lcg_state      = 32'hda456a02;
    rst_n_i        = 1'b0;
    in_valid_i     = 1'b0;
    in_data_i      = '0;
    tx_ready_i     = 1'b0;
    rx_valid_i     = 1'b0;
    rx_data_i      = '0;
    rx_credits_i   = '0;
    rx_cred_only_i = 1'b0;
    out_ready_i    = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < NUM_PHASES; i++) begin
      if (!timed_out) begin
        run_phase(i);
      end
    end
    if (!timed_out) begin
      drain_and_settle();
    end
    if (!timed_out) begin
      end_check <= 1'b1;
      @(negedge clk_i);
      end_check <= 1'b0;
      @(negedge clk_i);
    end
    $display("checks %0d, errors %0d, words %0d, credits-only packets %0d, timeout %0d",
             checks, errors, words_sent, cred_only_cnt, timed_out);
    if (timed_out || (errors != 0)) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule
